/* compile.f */
+incdir+.
gfx_ctrl_pkg.sv
gfx_regs.sv
gfx_irq.sv
gfx_rom_arbiter.sv
gfx_color_prom.sv
gfx_color_mixer.sv
gfx_ctrl_top.sv
gfx_ctrl_assertions.sv
tb_gfx_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gfx_ctrl
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_gfx_ctrl.sv */
// Directed testbench for the control core, with a reduced 16 pixel by 64 line frame and the TB acting as SDRAM
`timescale 1ns/100ps
`include "gfx_ctrl_defines.svh"

module tb_gfx_ctrl;

    import gfx_ctrl_pkg::*;

    logic                   clk;
    logic                   rst;
    logic                   pxl_cen;
    logic [8:0]             hdump;
    logic [8:0]             vdump;
    logic                   lhbl;
    logic                   lvbl;
    cpu_bus_t               cpu;
    logic [7:0]             dout;
    logic                   cpu_irqn;
    logic                   cpu_nmin;
    rom_req_t               scr_req;
    rom_req_t               obj_req;
    rom_rsp_t               scr_rsp;
    rom_rsp_t               obj_rsp;
    logic                   rom_cs;
    logic [`GFX_ROM_AW-1:0] rom_addr;
    logic                   rom_obj_sel;
    logic [`GFX_ROM_DW-1:0] rom_data;
    logic                   rom_ok;
    logic [1:0]             gfx_en;
    tile_pxl_t              tile_pxl;
    logic [`GFX_LUT_AW-1:0] obj_pxl;
    prom_wr_t               prom_wr;
    logic [`GFX_PXL_W-1:0]  pxl_out;
    logic                   flip;

    // Shadow copies of what the CPU wrote and the PROM contents
    logic [7:0]             regs [0:7];
    logic [3:0]             tile_lut [0:255];
    logic [3:0]             obj_lut [0:255];
    logic                   scan_run;

    gfx_ctrl_top u_gfx_ctrl_top (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .hdump       (hdump),
        .vdump       (vdump),
        .lhbl        (lhbl),
        .lvbl        (lvbl),
        .cpu         (cpu),
        .dout        (dout),
        .cpu_irqn    (cpu_irqn),
        .cpu_nmin    (cpu_nmin),
        .scr_req     (scr_req),
        .obj_req     (obj_req),
        .scr_rsp     (scr_rsp),
        .obj_rsp     (obj_rsp),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .rom_obj_sel (rom_obj_sel),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .gfx_en      (gfx_en),
        .tile_pxl    (tile_pxl),
        .obj_pxl     (obj_pxl),
        .prom_wr     (prom_wr),
        .pxl_out     (pxl_out),
        .flip        (flip)
    );

    always #5 clk = !clk;

    // Lines of 16 pixels with the last 4 blanked and lines 48 to 63 blanked
    always @(posedge clk) begin
        #1;
        if (scan_run && pxl_cen) begin
            if (hdump == 9'd15) begin
                hdump = 9'd0;
                vdump = (vdump == 9'd63) ? 9'd0 : vdump + 9'd1;
            end else begin
                hdump = hdump + 9'd1;
            end
            lhbl = (hdump < 9'd12);
            lvbl = (vdump < 9'd48);
        end
        pxl_cen = !pxl_cen;
    end

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic write_reg(input int a, input logic [7:0] d);
        cpu.cs   = 1'b1;
        cpu.rnw  = 1'b0;
        cpu.cen  = 1'b1;
        cpu.addr = a[2:0];
        cpu.din  = d;
        tick();
        cpu.cs   = 1'b0;
        cpu.rnw  = 1'b1;
        regs[a]  = d;
    endtask

    task automatic wait_frame_start;
        int n;
        n = 0;
        @(negedge clk);
        while (!(hdump == 9'd0 && vdump == 9'd0)) begin
            n++;
            if (n > 4096) begin
                fail_timeout("frame start");
            end
            @(negedge clk);
        end
    endtask

    task automatic readback_registers;
        for (int i = 0; i < 8; i++) begin
            write_reg(i, 8'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            cpu.addr = i[2:0];
            cpu.cs   = 1'b1;
            tick();
            check("dout", 32'(dout), 32'(regs[i]));
        end
        cpu.cs = 1'b0;
        check("flip", 32'(flip), 32'(regs[7][3]));
    endtask

    task automatic exercise_irq;
        int n;
        write_reg(7, 8'h02);
        n = 0;
        while (cpu_irqn !== 1'b0) begin
            n++;
            if (n > 4096) begin
                fail_timeout("cpu_irqn low");
            end
            tick();
        end
        @(negedge clk);
        check("lvbl", 32'(lvbl), 32'd0);
        n = 0;
        while (cpu_irqn !== 1'b1) begin
            n++;
            if (n > 64) begin
                fail_timeout("cpu_irqn release");
            end
            tick();
        end
        @(negedge clk);
        check("lhbl", 32'(lhbl), 32'd1);
        // No IRQ over a whole frame with irq_en clear
        write_reg(7, 8'h00);
        wait_frame_start();
        repeat (2100) begin
            tick();
            check("cpu_irqn", 32'(cpu_irqn), 32'd1);
        end
    endtask

    task automatic count_nmi_pulses(input logic pace);
        int pulses;
        int expected;
        logic last;
        write_reg(7, {3'b000, pace, 4'b0001});
        // Every 16th line, and only every 32nd with pacing on
        expected = 0;
        for (int i = 0; i < 64; i++) begin
            if ((i % 16 == 15) && (!pace || (i % 32 == 31))) begin
                expected++;
            end
        end
        wait_frame_start();
        pulses = 0;
        last   = cpu_nmin;
        repeat (2048) begin
            tick();
            if (last && !cpu_nmin) begin
                pulses++;
            end
            last = cpu_nmin;
        end
        check("nmi pulse count", 32'(pulses), 32'(expected));
        write_reg(7, 8'h00);
    endtask

    task automatic wait_rom_cs;
        int n;
        n = 0;
        while (rom_cs !== 1'b1) begin
            n++;
            if (n > 32) begin
                fail_timeout("rom_cs");
            end
            tick();
        end
    endtask

    // Acts as SDRAM for one access and answers after a few idle cycles
    task automatic serve_rom(input logic sel, input logic [17:0] addr, input int delay,
                             input logic [15:0] data);
        wait_rom_cs();
        check("rom_obj_sel", 32'(rom_obj_sel), 32'(sel));
        check("rom_addr", 32'(rom_addr), 32'(addr));
        repeat (delay) begin
            tick();
            check("rom_addr", 32'(rom_addr), 32'(addr));
            check("rom_obj_sel", 32'(rom_obj_sel), 32'(sel));
        end
        rom_data = data;
        rom_ok   = 1'b1;
        tick();
        rom_ok   = 1'b0;
    endtask

    task automatic wait_ok(input logic obj);
        int n;
        n = 0;
        while ((obj ? obj_rsp.ok : scr_rsp.ok) !== 1'b1) begin
            n++;
            if (n > 16) begin
                fail_timeout(obj ? "obj_rsp.ok" : "scr_rsp.ok");
            end
            tick();
        end
    endtask

    task automatic arbitrate_rom;
        logic [17:0] a1;
        logic [17:0] a2;
        logic [15:0] d1;
        logic [15:0] d2;
        a1 = 18'($urandom);
        a2 = 18'($urandom);
        d1 = 16'($urandom);
        d2 = 16'($urandom);
        gfx_en       = 2'b11;
        scr_req.cs   = 1'b1;
        scr_req.addr = a1;
        obj_req.cs   = 1'b1;
        obj_req.addr = a2;
        serve_rom(1'b0, a1, 4, d1);
        wait_ok(1'b0);
        check("scr_rsp.data", 32'(scr_rsp.data), 32'(d1));
        serve_rom(1'b1, a2, 2, d2);
        wait_ok(1'b1);
        check("obj_rsp.data", 32'(obj_rsp.data), 32'(d2));
        scr_req.cs = 1'b0;
        obj_req.cs = 1'b0;
        tick();
        check("rom_cs", 32'(rom_cs), 32'd0);
    endtask

    task automatic answer_disabled_obj;
        gfx_en       = 2'b01;
        obj_req.cs   = 1'b1;
        obj_req.addr = 18'($urandom);
        tick();
        check("obj_rsp.ok", 32'(obj_rsp.ok), 32'd1);
        check("obj_rsp.data", 32'(obj_rsp.data), 32'd0);
        check("rom_cs", 32'(rom_cs), 32'd0);
        obj_req.cs = 1'b0;
        gfx_en     = 2'b11;
        tick();
    endtask

    task automatic load_prom(input logic tile, input int a, input logic [3:0] d);
        prom_wr.we   = 1'b1;
        prom_wr.addr = {tile, a[7:0]};
        prom_wr.data = d;
        tick();
        prom_wr.we   = 1'b0;
        if (tile) begin
            tile_lut[a] = d;
        end else begin
            obj_lut[a] = d;
        end
    endtask

    function automatic logic [6:0] expect_pixel(input int h, input int v, input logic win,
                                                input logic [7:0] tidx, input logic [7:0] oidx);
        logic [3:0] tc;
        logic [3:0] oc;
        logic       tile_wins;
        tc = tile_lut[tidx];
        oc = obj_lut[oidx];
        if (v < 16 || h < 16 || h >= 272 || (regs[3][6] && (h < 24 || h >= 264))) begin
            return 7'd0;
        end
        tile_wins = (oc == 4'd0) || (regs[6][3] && win && tc != 4'd0);
        return tile_wins ? {regs[6][5:4], 1'b1, tc} : {regs[6][5:4], 1'b0, oc};
    endfunction

    task automatic show_pixel(input int h, input int v, input logic win,
                              input logic [7:0] tidx, input logic [7:0] oidx);
        hdump           = 9'(h);
        vdump           = 9'(v);
        tile_pxl.scrwin = win;
        tile_pxl.idx    = tidx;
        obj_pxl         = oidx;
        // Four pixel periods covers the PROM and output registers
        repeat (8) tick();
        check("pxl_out", 32'(pxl_out), 32'(expect_pixel(h, v, win, tidx, oidx)));
    endtask

    task automatic compare_mixer_pixels;
        for (int i = 0; i < 256; i++) begin
            load_prom(1'b1, i, 4'($urandom));
            load_prom(1'b0, i, 4'($urandom));
        end
        load_prom(1'b0, 0, 4'd0);
        load_prom(1'b0, 1, 4'($urandom % 15) + 4'd1);
        load_prom(1'b1, 2, 4'($urandom % 15) + 4'd1);
        load_prom(1'b1, 3, 4'd0);
        scan_run = 1'b0;
        write_reg(3, 8'h00);
        for (int b = 0; b < 4; b++) begin
            write_reg(6, 8'(b << 4));
            show_pixel(100, 40, 1'b1, 8'd2, 8'd0);
            show_pixel(100, 40, 1'b1, 8'd2, 8'd1);
        end
        // Window priority on
        write_reg(6, 8'h18);
        show_pixel(120, 40, 1'b1, 8'd2, 8'd1);
        show_pixel(120, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(120, 40, 1'b1, 8'd3, 8'd1);
        for (int i = 0; i < 8; i++) begin
            show_pixel(140, 50, 1'($urandom), 8'($urandom), 8'($urandom));
        end
        // Wide then narrow borders, then the top lines
        show_pixel(15, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(16, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(271, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(272, 40, 1'b0, 8'd2, 8'd1);
        write_reg(3, 8'h40);
        show_pixel(23, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(24, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(263, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(264, 40, 1'b0, 8'd2, 8'd1);
        show_pixel(100, 15, 1'b0, 8'd2, 8'd1);
        show_pixel(100, 16, 1'b0, 8'd2, 8'd1);
    endtask

    initial begin
        void'($urandom(32'hd6b));
        clk      = 1'b0;
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        hdump    = 9'd0;
        vdump    = 9'd0;
        lhbl     = 1'b1;
        lvbl     = 1'b1;
        scan_run = 1'b1;
        cpu      = '0;
        cpu.rnw  = 1'b1;
        scr_req  = '0;
        obj_req  = '0;
        rom_data = '0;
        rom_ok   = 1'b0;
        gfx_en   = 2'b11;
        tile_pxl = '0;
        obj_pxl  = '0;
        prom_wr  = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();
        readback_registers();
        exercise_irq();
        count_nmi_pulses(1'b0);
        count_nmi_pulses(1'b1);
        arbitrate_rom();
        answer_disabled_obj();
        compare_mixer_pixels();
        $display("Test passed");
        $finish;
    end

endmodule

/* gfx_ctrl_assertions.sv */
// Checks on the SDRAM port and interrupt outputs, assuming a sample every fourth pixel as in gfx_irq
`timescale 1ns/100ps
`include "gfx_ctrl_defines.svh"

module gfx_ctrl_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   pxl_cen,
    input logic [8:0]             hdump,
    input logic                   rom_cs,
    input logic [`GFX_ROM_AW-1:0] rom_addr,
    input logic                   rom_obj_sel,
    input logic                   rom_ok,
    input logic                   cpu_nmin,
    input logic                   cpu_irqn,
    input gfx_ctrl_pkg::gfx_cfg_t cfg
);

    logic       sample;
    logic       nmin_last;
    logic [3:0] irq_off_cnt;

    assign sample = pxl_cen && (hdump[1:0] == 2'b11);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            nmin_last   <= 1'b1;
            irq_off_cnt <= '0;
        end else begin
            if (sample) begin
                nmin_last <= cpu_nmin;
            end
            // Saturating count of cycles since irq_en was last set
            if (cfg.irq_en) begin
                irq_off_cnt <= '0;
            end else if (irq_off_cnt != 4'hf) begin
                irq_off_cnt <= irq_off_cnt + 4'd1;
            end
        end
    end

    addr_held: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && $past(rom_cs) && !$past(rom_ok)) |-> ($stable(rom_addr) && $stable(rom_obj_sel)))
        else $error("rom_addr or rom_obj_sel moved during an access");

    cs_in_reset: assert property (@(posedge clk) rst |-> !rom_cs)
        else $error("rom_cs high during reset");

    nmi_single: assert property (@(posedge clk) disable iff (rst)
        sample |-> (cpu_nmin || nmin_last))
        else $error("cpu_nmin low for two samples");

    // Allow one sample period for the release after irq_en clears
    irq_off: assert property (@(posedge clk) disable iff (rst)
        (irq_off_cnt >= 4'd10) |-> cpu_irqn)
        else $error("cpu_irqn low with irq_en clear");

endmodule

bind gfx_ctrl_top gfx_ctrl_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .pxl_cen     (pxl_cen),
    .hdump       (hdump),
    .rom_cs      (rom_cs),
    .rom_addr    (rom_addr),
    .rom_obj_sel (rom_obj_sel),
    .rom_ok      (rom_ok),
    .cpu_nmin    (cpu_nmin),
    .cpu_irqn    (cpu_irqn),
    .cfg         (cfg)
);

/* gfx_ctrl_top.sv */
// Control core only, with the pixel engines and video RAMs outside and everything on the single clk
`timescale 1ns/100ps
`include "gfx_ctrl_defines.svh"

module gfx_ctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    // Video timing
    input  logic                    pxl_cen,
    input  logic [8:0]              hdump,
    input  logic [8:0]              vdump,
    input  logic                    lhbl,
    input  logic                    lvbl,
    // CPU
    input  gfx_ctrl_pkg::cpu_bus_t  cpu,
    output logic [7:0]              dout,
    output logic                    cpu_irqn,
    output logic                    cpu_nmin,
    // Engine ROM requests
    input  gfx_ctrl_pkg::rom_req_t  scr_req,
    input  gfx_ctrl_pkg::rom_req_t  obj_req,
    output gfx_ctrl_pkg::rom_rsp_t  scr_rsp,
    output gfx_ctrl_pkg::rom_rsp_t  obj_rsp,
    // SDRAM
    output logic                    rom_cs,
    output logic [`GFX_ROM_AW-1:0]  rom_addr,
    output logic                    rom_obj_sel,
    input  logic [`GFX_ROM_DW-1:0]  rom_data,
    input  logic                    rom_ok,
    input  logic [1:0]              gfx_en,
    // Pixels
    input  gfx_ctrl_pkg::tile_pxl_t tile_pxl,
    input  logic [`GFX_LUT_AW-1:0]  obj_pxl,
    input  gfx_ctrl_pkg::prom_wr_t  prom_wr,
    output logic [`GFX_PXL_W-1:0]   pxl_out,
    output logic                    flip
);

    import gfx_ctrl_pkg::*;

    gfx_cfg_t cfg;

    assign flip = cfg.flip;

    gfx_regs u_regs (
        .clk  (clk),
        .rst  (rst),
        .cpu  (cpu),
        .dout (dout),
        .cfg  (cfg)
    );

    gfx_irq u_irq (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .cfg      (cfg),
        .cpu_irqn (cpu_irqn),
        .cpu_nmin (cpu_nmin)
    );

    gfx_rom_arbiter u_rom_arbiter (
        .clk         (clk),
        .rst         (rst),
        .gfx_en      (gfx_en),
        .scr_req     (scr_req),
        .obj_req     (obj_req),
        .scr_rsp     (scr_rsp),
        .obj_rsp     (obj_rsp),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .rom_obj_sel (rom_obj_sel),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok)
    );

    gfx_color_mixer u_color_mixer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .cfg      (cfg),
        .tile_pxl (tile_pxl),
        .obj_pxl  (obj_pxl),
        .prom_wr  (prom_wr),
        .pxl_out  (pxl_out)
    );

endmodule

/* gfx_color_mixer.sv */
// Pixel indices must be held two clocks before the pxl_cen that takes them, and the border follows the live dump position
`timescale 1ns/100ps
`include "gfx_ctrl_defines.svh"

module gfx_color_mixer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic [8:0]              hdump,
    input  logic [8:0]              vdump,
    input  gfx_ctrl_pkg::gfx_cfg_t  cfg,
    input  gfx_ctrl_pkg::tile_pxl_t tile_pxl,
    input  logic [`GFX_LUT_AW-1:0]  obj_pxl,
    input  gfx_ctrl_pkg::prom_wr_t  prom_wr,
    output logic [`GFX_PXL_W-1:0]   pxl_out
);

    import gfx_ctrl_pkg::*;

    tile_pxl_t              tile_q;
    logic [`GFX_LUT_AW-1:0] obj_q;
    logic                   scrwin_q;
    logic [`GFX_LUT_DW-1:0] tile_col;
    logic [`GFX_LUT_DW-1:0] obj_col;
    logic                   border_wide;
    logic                   border_narrow;
    logic                   blank_area;
    logic                   tile_sel;

    // Lookup addresses, and scrwin delayed to meet the PROM output
    always_ff @(posedge clk) begin
        tile_q   <= tile_pxl;
        obj_q    <= obj_pxl;
        scrwin_q <= tile_q.scrwin;
    end

    gfx_color_prom u_tile_prom (
        .clk     (clk),
        .we      (prom_wr.we && prom_wr.addr[`GFX_LUT_AW]),
        .wr_addr (prom_wr.addr[`GFX_LUT_AW-1:0]),
        .wr_data (prom_wr.data),
        .rd_addr (tile_q.idx),
        .q       (tile_col)
    );

    gfx_color_prom u_obj_prom (
        .clk     (clk),
        .we      (prom_wr.we && !prom_wr.addr[`GFX_LUT_AW]),
        .wr_addr (prom_wr.addr[`GFX_LUT_AW-1:0]),
        .wr_data (prom_wr.data),
        .rd_addr (obj_q),
        .q       (obj_col)
    );

    assign border_wide   = (hdump < `GFX_BORDER_WIDE_LO) || (hdump >= `GFX_BORDER_WIDE_HI);
    assign border_narrow = cfg.narrow_en &&
                           ((hdump < `GFX_BORDER_NARROW_LO) || (hdump >= `GFX_BORDER_NARROW_HI));
    assign blank_area    = (vdump < `GFX_VBLANK_TOP) || border_wide || border_narrow;

    // Tile wins over a transparent object or inside the window
    assign tile_sel = (obj_col == '0) ||
                      (cfg.scrwin_en && scrwin_q && (tile_col != '0));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pxl_out <= '1;
        end else if (pxl_cen) begin
            if (blank_area) begin
                pxl_out <= '0;
            end else if (tile_sel) begin
                pxl_out <= {cfg.pal_bank, 1'b1, tile_col};
            end else begin
                pxl_out <= {cfg.pal_bank, 1'b0, obj_col};
            end
        end
    end

endmodule

/* gfx_color_prom.sv */
// Colour lookup PROM with one cycle read latency and no reset, so contents are unknown until loaded
`timescale 1ns/100ps
`include "gfx_ctrl_defines.svh"

module gfx_color_prom (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`GFX_LUT_AW-1:0] wr_addr,
    input  logic [`GFX_LUT_DW-1:0] wr_data,
    input  logic [`GFX_LUT_AW-1:0] rd_addr,
    output logic [`GFX_LUT_DW-1:0] q
);

    logic [`GFX_LUT_DW-1:0] mem [0:(1 << `GFX_LUT_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        // Read sees the old word on a same address write
        q <= mem[rd_addr];
    end

endmodule

/* gfx_rom_arbiter.sv */
// Shares one SDRAM port between two level requesters and expects rom_ok no earlier than two cycles after rom_cs
`timescale 1ns/100ps
`include "gfx_ctrl_defines.svh"

module gfx_rom_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             gfx_en,
    input  gfx_ctrl_pkg::rom_req_t scr_req,
    input  gfx_ctrl_pkg::rom_req_t obj_req,
    output gfx_ctrl_pkg::rom_rsp_t scr_rsp,
    output gfx_ctrl_pkg::rom_rsp_t obj_rsp,
    output logic                   rom_cs,
    output logic [`GFX_ROM_AW-1:0] rom_addr,
    output logic                   rom_obj_sel,
    input  logic [`GFX_ROM_DW-1:0] rom_data,
    input  logic                   rom_ok
);

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_SCR,
        OWN_OBJ
    } owner_t;

    owner_t                 owner;
    logic                   settle;
    logic [1:0]             last_cs;
    logic                   scr_ok;
    logic                   obj_ok;
    logic [`GFX_ROM_DW-1:0] scr_data;
    logic [`GFX_ROM_DW-1:0] obj_data;
    logic                   scr_rise;
    logic                   obj_rise;
    logic                   scr_pend;
    logic                   obj_pend;
    logic                   done;

    assign scr_rise = scr_req.cs && !last_cs[0];
    assign obj_rise = obj_req.cs && !last_cs[1];

    // A held request that was already answered is not served twice
    assign scr_pend = scr_req.cs && gfx_en[0] && (scr_rise || !scr_ok);
    assign obj_pend = obj_req.cs && gfx_en[1] && (obj_rise || !obj_ok);

    // First rom_ok after the settle cycle ends the access
    assign done = (owner != OWN_IDLE) && settle && rom_ok;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            owner       <= OWN_IDLE;
            settle      <= 1'b0;
            last_cs     <= 2'b00;
            rom_cs      <= 1'b0;
            rom_obj_sel <= 1'b0;
            scr_ok      <= 1'b0;
            obj_ok      <= 1'b0;
        end else begin
            last_cs <= {obj_req.cs, scr_req.cs};
            // New request clears ok, or answers at once when disabled
            if (scr_rise) begin
                scr_ok <= !gfx_en[0];
            end
            if (obj_rise) begin
                obj_ok <= !gfx_en[1];
            end
            if (owner == OWN_IDLE) begin
                settle <= 1'b0;
                if (scr_pend) begin
                    owner       <= OWN_SCR;
                    rom_cs      <= 1'b1;
                    rom_obj_sel <= 1'b0;
                end else if (obj_pend) begin
                    owner       <= OWN_OBJ;
                    rom_cs      <= 1'b1;
                    rom_obj_sel <= 1'b1;
                end
            end else if (done) begin
                owner  <= OWN_IDLE;
                rom_cs <= 1'b0;
                if (owner == OWN_SCR) begin
                    scr_ok <= 1'b1;
                end else begin
                    obj_ok <= 1'b1;
                end
            end else begin
                settle <= 1'b1;
            end
        end
    end

    // Address and returned words
    always_ff @(posedge clk) begin
        if (owner == OWN_IDLE) begin
            if (scr_pend) begin
                rom_addr <= scr_req.addr;
            end else if (obj_pend) begin
                rom_addr <= obj_req.addr;
            end
        end
        if (scr_rise && !gfx_en[0]) begin
            scr_data <= '0;
        end
        if (obj_rise && !gfx_en[1]) begin
            obj_data <= '0;
        end
        if (done && owner == OWN_SCR) begin
            scr_data <= rom_data;
        end
        if (done && owner == OWN_OBJ) begin
            obj_data <= rom_data;
        end
    end

    assign scr_rsp.ok   = scr_ok;
    assign scr_rsp.data = scr_data;
    assign obj_rsp.ok   = obj_ok;
    assign obj_rsp.data = obj_data;

endmodule

/* gfx_irq.sv */
// Frame IRQ and line NMI sampled once every four pixels, so blanking edges must last a full sample
`timescale 1ns/100ps

module gfx_irq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic [8:0]             hdump,
    input  logic [8:0]             vdump,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  gfx_ctrl_pkg::gfx_cfg_t cfg,
    output logic                   cpu_irqn,
    output logic                   cpu_nmin
);

    logic sample;
    logic last_lvbl;
    logic last_lhbl;
    logic vbl_fall;
    logic hbl_fall;
    logic nmi_line;

    assign sample   = pxl_cen && (hdump[1:0] == 2'b11);
    assign vbl_fall = !lvbl && last_lvbl;
    assign hbl_fall = !lhbl && last_lhbl;

    // Every 16th line, or every 32nd with pacing on
    assign nmi_line = (&vdump[3:0]) && (vdump[4] || !cfg.nmi_pace);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cpu_irqn  <= 1'b1;
            cpu_nmin  <= 1'b1;
            last_lvbl <= 1'b0;
            last_lhbl <= 1'b0;
        end else if (sample) begin
            last_lvbl <= lvbl;
            last_lhbl <= lhbl;
            if (vbl_fall && cfg.irq_en) begin
                cpu_irqn <= 1'b0;
            end else if (lhbl || !cfg.irq_en) begin
                cpu_irqn <= 1'b1;
            end
            // Low for one sample period only
            cpu_nmin <= !(cfg.nmi_en && hbl_fall && nmi_line);
        end
    end

endmodule

/* gfx_regs.sv */
// CPU register file on clk only, so the bus must hold a write until a clock where cen is high
`timescale 1ns/100ps
`include "gfx_ctrl_defines.svh"

module gfx_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  gfx_ctrl_pkg::cpu_bus_t cpu,
    output logic [7:0]             dout,
    output gfx_ctrl_pkg::gfx_cfg_t cfg
);

    logic [7:0] mmr [0:`GFX_MMR_COUNT-1];
    logic       wr_en;

    assign wr_en = cpu.cs && cpu.cen && !cpu.rnw;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `GFX_MMR_COUNT; i++) begin
                mmr[i] <= '0;
            end
        end else if (wr_en) begin
            mmr[cpu.addr] <= cpu.din;
        end
    end

    // Read data follows the address without a register
    assign dout = mmr[cpu.addr];

    // Register 7 holds interrupt control and flip
    assign cfg.nmi_en    = mmr[7][0];
    assign cfg.irq_en    = mmr[7][1];
    assign cfg.flip      = mmr[7][3];
    assign cfg.nmi_pace  = mmr[7][4];

    // Register 6 holds colour control
    assign cfg.scrwin_en = mmr[6][3];
    assign cfg.pal_bank  = mmr[6][5:4];

    // Only the narrow layout bit survives without strip scroll
    assign cfg.narrow_en = mmr[3][6];

endmodule

/* gfx_ctrl_pkg.sv */
// Bus and field types of the video control core, and the register data bus is fixed at 8 bits
`include "gfx_ctrl_defines.svh"

package gfx_ctrl_pkg;

    // One CPU access where writes only count with cen high
    typedef struct packed {
        logic                    cs;
        logic                    rnw;
        logic                    cen;
        logic [`GFX_MMR_AW-1:0]  addr;
        logic [7:0]              din;
    } cpu_bus_t;

    // Fields decoded from registers 3, 6 and 7
    typedef struct packed {
        logic       nmi_en;
        logic       irq_en;
        logic       flip;
        logic       nmi_pace;
        logic       scrwin_en;
        logic [1:0] pal_bank;
        logic       narrow_en;
    } gfx_cfg_t;

    // Level request from a pixel engine
    typedef struct packed {
        logic                   cs;
        logic [`GFX_ROM_AW-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic                   ok;
        logic [`GFX_ROM_DW-1:0] data;
    } rom_rsp_t;

    typedef struct packed {
        logic                   scrwin;
        logic [`GFX_LUT_AW-1:0] idx;
    } tile_pxl_t;

    // Address bit 8 picks the tile PROM when set
    typedef struct packed {
        logic                   we;
        logic [`GFX_LUT_AW:0]   addr;
        logic [`GFX_LUT_DW-1:0] data;
    } prom_wr_t;

endpackage

/* gfx_ctrl_defines.svh */
// Sizes and screen limits for the video control core, so widths here must match the engine ports
`ifndef GFX_CTRL_DEFINES_SVH
`define GFX_CTRL_DEFINES_SVH

// Register file
`define GFX_MMR_COUNT 8
`define GFX_MMR_AW 3

// SDRAM port shared by the tilemap and object engines
`define GFX_ROM_AW 18
`define GFX_ROM_DW 16

// Colour PROMs and output pixel
`define GFX_LUT_AW 8
`define GFX_LUT_DW 4
`define GFX_PXL_W 7

// Horizontal border in dump columns
`define GFX_BORDER_WIDE_LO 16
`define GFX_BORDER_WIDE_HI 272
`define GFX_BORDER_NARROW_LO 24
`define GFX_BORDER_NARROW_HI 264

// Lines blanked at the top of the frame
`define GFX_VBLANK_TOP 16

`endif
